// File: common/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// core sizes for the rv32i integer pipeline.

// data path word.
`define XLEN 32

// register file addressing.
`define REG_ADDR_WIDTH 5

// architectural registers, x0 included.
`define NUM_REGS 32

// width of the alu operation code.
`define ALU_OP_WIDTH 4

`endif

// File: common/riscv_pkg.sv
`include "riscv_params.svh"

`default_nettype none

package riscv_pkg;

	localparam logic [6:0] OPC_OP    = 7'b0110011; // register-register alu.
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // immediate alu.
	localparam logic [6:0] OPC_LUI   = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra.

	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // lui.
	} alu_op_e;

	typedef struct packed {
		logic [6:0]                 funct7;
		logic [`REG_ADDR_WIDTH-1:0] rs2;
		logic [`REG_ADDR_WIDTH-1:0] rs1;
		logic [2:0]                 funct3;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [6:0]                 opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]                imm12;
		logic [`REG_ADDR_WIDTH-1:0] rs1;
		logic [2:0]                 funct3;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [6:0]                 opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [19:0]                imm20;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [6:0]                 opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t           r;
		i_fmt_t           i;
		u_fmt_t           u;
		logic [`XLEN-1:0] raw;
	} instr_u;

	// decoded fields produced by the control unit.
	typedef struct packed {
		logic                       illegal;
		alu_op_e                    alu_op;
		logic                       imm_sel; // operand b is the immediate.
		logic                       pc_sel;  // operand a is the pc.
		logic [`XLEN-1:0]           imm;
		logic [`REG_ADDR_WIDTH-1:0] rd;
	} ctrl_t;

	typedef struct packed {
		logic                       valid;
		logic                       illegal;
		alu_op_e                    alu_op;
		logic                       imm_sel;
		logic                       pc_sel;
		logic [`REG_ADDR_WIDTH-1:0] rs1;
		logic [`REG_ADDR_WIDTH-1:0] rs2;
		logic [`XLEN-1:0]           rdata1;
		logic [`XLEN-1:0]           rdata2;
		logic [`XLEN-1:0]           imm;
		logic [`XLEN-1:0]           pc;
		logic [`REG_ADDR_WIDTH-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic                       valid;
		logic                       illegal;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [`XLEN-1:0]           data;
	} wb_t;

endpackage

`default_nettype wire

// File: id/reg_bank.sv
`include "riscv_params.svh"

`default_nettype none

module reg_bank
	(
		input  logic                       clk,
		input  logic                       reset_i,
		input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
		input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
		input  riscv_pkg::wb_t             wb_i,
		output logic [`XLEN-1:0]           rdata1_o,
		output logic [`XLEN-1:0]           rdata2_o
	);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic             wr_en;

	// x0 is never written, so it keeps its reset value.
	assign wr_en = wb_i.valid && !wb_i.illegal && (wb_i.rd != '0);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	// a write in the same cycle bypasses the array.
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_WIDTH-1:0] addr);
		if (wr_en && (wb_i.rd == addr)) begin
			return wb_i.data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdata1_o = read_port(rs1_addr_i);
		rdata2_o = read_port(rs2_addr_i);
	end

endmodule

`default_nettype wire

// File: id/control_unit.sv
`include "riscv_params.svh"

`default_nettype none

module control_unit
	(
		input  riscv_pkg::instr_u instr_i,
		output riscv_pkg::ctrl_t  ctrl_o
	);

	import riscv_pkg::*;

	logic [`XLEN-1:0] imm_i_type;
	logic [`XLEN-1:0] imm_u_type;

	// sign-extended i immediate and upper u immediate.
	assign imm_i_type = {{(`XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
	assign imm_u_type = {instr_i.u.imm20, 12'b0};

	always_comb begin
		ctrl_o.illegal = 1'b0;
		ctrl_o.alu_op  = ALU_ADD;
		ctrl_o.imm_sel = 1'b0;
		ctrl_o.pc_sel  = 1'b0;
		ctrl_o.imm     = imm_i_type;
		ctrl_o.rd      = instr_i.r.rd; // same position in every kept format.

		case (instr_i.r.opcode)
			OPC_OP: begin
				if (instr_i.r.funct7 == F7_BASE) begin
					case (instr_i.r.funct3)
						3'b000: ctrl_o.alu_op = ALU_ADD;
						3'b001: ctrl_o.alu_op = ALU_SLL;
						3'b010: ctrl_o.alu_op = ALU_SLT;
						3'b011: ctrl_o.alu_op = ALU_SLTU;
						3'b100: ctrl_o.alu_op = ALU_XOR;
						3'b101: ctrl_o.alu_op = ALU_SRL;
						3'b110: ctrl_o.alu_op = ALU_OR;
						default: ctrl_o.alu_op = ALU_AND;
					endcase
				end else if (instr_i.r.funct7 == F7_ALT && instr_i.r.funct3 == 3'b000) begin
					ctrl_o.alu_op = ALU_SUB;
				end else if (instr_i.r.funct7 == F7_ALT && instr_i.r.funct3 == 3'b101) begin
					ctrl_o.alu_op = ALU_SRA;
				end else begin
					ctrl_o.illegal = 1'b1;
				end
			end

			OPC_OP_IMM: begin
				ctrl_o.imm_sel = 1'b1;
				case (instr_i.i.funct3)
					3'b000: ctrl_o.alu_op = ALU_ADD;
					3'b010: ctrl_o.alu_op = ALU_SLT;
					3'b011: ctrl_o.alu_op = ALU_SLTU;
					3'b100: ctrl_o.alu_op = ALU_XOR;
					3'b110: ctrl_o.alu_op = ALU_OR;
					3'b111: ctrl_o.alu_op = ALU_AND;
					// shifts reuse the funct7 slot of the r view.
					3'b001: begin
						ctrl_o.alu_op  = ALU_SLL;
						ctrl_o.illegal = (instr_i.r.funct7 != F7_BASE);
					end
					default: begin
						if (instr_i.r.funct7 == F7_ALT) begin
							ctrl_o.alu_op = ALU_SRA;
						end else begin
							ctrl_o.alu_op  = ALU_SRL;
							ctrl_o.illegal = (instr_i.r.funct7 != F7_BASE);
						end
					end
				endcase
			end

			OPC_LUI: begin
				ctrl_o.alu_op  = ALU_PASS_B;
				ctrl_o.imm_sel = 1'b1;
				ctrl_o.imm     = imm_u_type;
			end

			OPC_AUIPC: begin
				ctrl_o.imm_sel = 1'b1;
				ctrl_o.pc_sel  = 1'b1; // pc + upper immediate.
				ctrl_o.imm     = imm_u_type;
			end

			default: ctrl_o.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: id/id_stage.sv
`include "riscv_params.svh"

`default_nettype none

module id_stage
	(
		input  logic              clk,
		input  logic              reset_i,

		// instruction stream from the environment
		input  logic              instr_valid_i,
		input  riscv_pkg::instr_u instr_i,
		input  logic [`XLEN-1:0]  pc_i,

		// register bank write port, fed back from the writeback register
		input  riscv_pkg::wb_t    wb_i,

		// payload to execute
		output riscv_pkg::id_ex_t id_ex_o
	);

	import riscv_pkg::*;

	logic [`REG_ADDR_WIDTH-1:0] addr_rs1;
	logic [`REG_ADDR_WIDTH-1:0] addr_rs2;
	logic [`XLEN-1:0]           rdata1;
	logic [`XLEN-1:0]           rdata2;
	ctrl_t                      ctrl;
	id_ex_t                     id_ex_d;

	assign addr_rs1 = instr_i.r.rs1;
	assign addr_rs2 = instr_i.r.rs2; // only meaningful for r-type.

	reg_bank regbank
		(
			.clk(clk),
			.reset_i(reset_i),
			.rs1_addr_i(addr_rs1),
			.rs2_addr_i(addr_rs2),
			.wb_i(wb_i),
			.rdata1_o(rdata1),
			.rdata2_o(rdata2)
		);

	control_unit ctrl_unit
		(
			.instr_i(instr_i),
			.ctrl_o(ctrl)
		);

	always_comb begin
		id_ex_d.valid   = instr_valid_i;
		id_ex_d.illegal = ctrl.illegal;
		id_ex_d.alu_op  = ctrl.alu_op;
		id_ex_d.imm_sel = ctrl.imm_sel;
		id_ex_d.pc_sel  = ctrl.pc_sel;
		id_ex_d.rs1     = addr_rs1; // kept for forwarding in execute.
		id_ex_d.rs2     = addr_rs2;
		id_ex_d.rdata1  = rdata1;
		id_ex_d.rdata2  = rdata2;
		id_ex_d.imm     = ctrl.imm;
		id_ex_d.pc      = pc_i;
		id_ex_d.rd      = ctrl.rd;
	end

	// decode-to-execute pipeline register.
	always_ff @(posedge clk) begin
		id_ex_o <= id_ex_d;
		if (reset_i) begin
			id_ex_o.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/alu.sv
`include "riscv_params.svh"

`default_nettype none

module alu
	(
		input  riscv_pkg::alu_op_e op_i,
		input  logic [`XLEN-1:0]   a_i,
		input  logic [`XLEN-1:0]   b_i,
		output logic [`XLEN-1:0]   result_o
	);

	import riscv_pkg::*;

	localparam int SHAMT_W = $clog2(`XLEN);

	logic [SHAMT_W-1:0] shamt;
	logic               lt_signed;
	logic               lt_unsigned;

	assign shamt       = b_i[SHAMT_W-1:0]; // upper bits of b ignored.
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		case (op_i)
			ALU_ADD:    result_o = a_i + b_i;
			ALU_SUB:    result_o = a_i - b_i;
			ALU_SLL:    result_o = a_i << shamt;
			ALU_SLT:    result_o = {{(`XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU:   result_o = {{(`XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:    result_o = a_i ^ b_i;
			ALU_SRL:    result_o = a_i >> shamt;
			ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
			ALU_OR:     result_o = a_i | b_i;
			ALU_AND:    result_o = a_i & b_i;
			ALU_PASS_B: result_o = b_i;
			default:    result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/ex_stage.sv
`include "riscv_params.svh"

`default_nettype none

module ex_stage
	(
		input  logic              clk,
		input  logic              reset_i,

		// payload from decode
		input  riscv_pkg::id_ex_t id_ex_i,

		// writeback register, also the forwarding source
		output riscv_pkg::wb_t    wb_o
	);

	logic             fwd_ok;
	logic             fwd_rs1;
	logic             fwd_rs2;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_result;

	// same condition as the register bank write.
	assign fwd_ok = wb_o.valid && !wb_o.illegal && (wb_o.rd != '0);

	assign fwd_rs1 = fwd_ok && (wb_o.rd == id_ex_i.rs1);
	assign fwd_rs2 = fwd_ok && (wb_o.rd == id_ex_i.rs2);

	assign rs1_val = fwd_rs1 ? wb_o.data : id_ex_i.rdata1;
	assign rs2_val = fwd_rs2 ? wb_o.data : id_ex_i.rdata2;

	// auipc takes the pc and immediate forms take imm.
	assign op_a = id_ex_i.pc_sel ? id_ex_i.pc : rs1_val;
	assign op_b = id_ex_i.imm_sel ? id_ex_i.imm : rs2_val;

	alu alu_unit
		(
			.op_i(id_ex_i.alu_op),
			.a_i(op_a),
			.b_i(op_b),
			.result_o(alu_result)
		);

	always_ff @(posedge clk) begin
		wb_o.illegal <= id_ex_i.illegal;
		wb_o.rd      <= id_ex_i.rd;
		wb_o.data    <= alu_result;
		if (reset_i) begin
			wb_o.valid <= 1'b0;
		end else begin
			wb_o.valid <= id_ex_i.valid;
		end
	end

endmodule

`default_nettype wire

// File: source/int_pipe_top.sv
`include "riscv_params.svh"

`default_nettype none

module int_pipe_top
	(
		input  logic              clk,
		input  logic              reset_i,
		input  logic              instr_valid_i,
		input  riscv_pkg::instr_u instr_i,
		input  logic [`XLEN-1:0]  pc_i,
		output riscv_pkg::wb_t    wb_o
	);

	import riscv_pkg::*;

	id_ex_t id_ex;
	wb_t    wb;

	id_stage id_stg
		(
			.clk(clk),
			.reset_i(reset_i),
			.instr_valid_i(instr_valid_i),
			.instr_i(instr_i),
			.pc_i(pc_i),
			.wb_i(wb), // register bank write port.
			.id_ex_o(id_ex)
		);

	ex_stage ex_stg
		(
			.clk(clk),
			.reset_i(reset_i),
			.id_ex_i(id_ex),
			.wb_o(wb)
		);

	assign wb_o = wb;

endmodule

`default_nettype wire

// File: sim/int_pipe_tb.sv
`include "riscv_params.svh"

`default_nettype none

module int_pipe_tb;

	import riscv_pkg::*;

	localparam int MAX_LINES = 64;
	localparam int FIELDS    = 6; // words per stimulus line.
	localparam int RESET_CYC = 16;
	localparam int DRAIN_CYC = 20;

	typedef struct packed {
		int  due;  // negedge count at which wb_o is sampled.
		int  line;
		wb_t exp;
	} pending_t;

	logic             clk;
	logic             reset_i;
	logic             instr_valid_i;
	instr_u           instr_i;
	logic [`XLEN-1:0] pc_i;
	wb_t              wb_o;

	logic [31:0] stim_mem [0:MAX_LINES*FIELDS-1];
	pending_t    pending_q [$];
	int          num_lines;
	int          cycle_limit;
	int          cycle_cnt;
	int          neg_cnt;
	int          pass_cnt;
	int          fail_cnt;

	int_pipe_top dut
		(
			.clk(clk),
			.reset_i(reset_i),
			.instr_valid_i(instr_valid_i),
			.instr_i(instr_i),
			.pc_i(pc_i),
			.wb_o(wb_o)
		);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// drives one stimulus line and queues its writeback.
	task automatic drive_line(input int n);
		pending_t entry;
		int       base;
		base = n * FIELDS;
		pc_i          <= stim_mem[base];
		instr_i       <= stim_mem[base + 1];
		instr_valid_i <= stim_mem[base + 2][0];
		entry.due         = neg_cnt + 3; // sampled mid cycle after two edges of latency.
		entry.line        = n;
		entry.exp.valid   = stim_mem[base + 2][0];
		entry.exp.illegal = stim_mem[base + 3][0];
		entry.exp.rd      = stim_mem[base + 4][`REG_ADDR_WIDTH-1:0];
		entry.exp.data    = stim_mem[base + 5];
		pending_q.push_back(entry);
	endtask

	task automatic compare_wb(input int line, input wb_t exp, input wb_t act);
		int errs;
		errs = 0;
		if (act.valid !== exp.valid) begin
			if (exp.valid) begin
				$display("line %0d: no writeback arrived two cycles after the strobe", line);
			end else begin
				$display("line %0d: a writeback arrived without any strobe", line);
			end
			errs++;
		end else if (exp.valid) begin
			if (act.illegal !== exp.illegal) begin
				$display("Error: line %0d wb_o.illegal expected %h got %h",
					line, exp.illegal, act.illegal);
				errs++;
			end
			if (act.rd !== exp.rd) begin
				$display("Error: line %0d wb_o.rd expected %h got %h", line, exp.rd, act.rd);
				errs++;
			end
			// data of an illegal instruction carries no meaning.
			if (!exp.illegal && act.data !== exp.data) begin
				$display("Error: line %0d wb_o.data expected %h got %h",
					line, exp.data, act.data);
				errs++;
			end
		end
		if (errs == 0) begin
			pass_cnt++;
			$display("line %0d: ok", line);
		end else begin
			fail_cnt++;
			$display("line %0d: mismatch", line);
		end
	endtask

	always @(negedge clk) begin : sample_wb
		pending_t entry;
		neg_cnt = neg_cnt + 1;
		if (pending_q.size() > 0) begin
			entry = pending_q[0];
			if (entry.due == neg_cnt) begin
				entry = pending_q.pop_front();
				compare_wb(entry.line, entry.exp, wb_o);
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("run stopped after %0d cycles with writebacks still pending", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		reset_i       = 1'b1;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		pc_i          = '0;
		pass_cnt      = 0;
		fail_cnt      = 0;
		cycle_cnt     = 0;
		neg_cnt       = 0;
		num_lines     = 0;
		$readmemh("sim/int_pipe_stimulus.txt", stim_mem);
		while (num_lines < MAX_LINES && !$isunknown(stim_mem[num_lines * FIELDS])) begin
			num_lines++;
		end
		cycle_limit = RESET_CYC + num_lines + DRAIN_CYC;
		if (num_lines == 0) begin
			$display("no stimulus lines could be read");
		end

		repeat (RESET_CYC) @(posedge clk);
		reset_i <= 1'b0;
		for (int n = 0; n < num_lines; n++) begin
			@(posedge clk);
			drive_line(n);
		end
		@(posedge clk);
		instr_valid_i <= 1'b0;
		while (pending_q.size() > 0) begin
			@(posedge clk);
		end

		$display("%0d tests, %0d passed, %0d failed", num_lines, pass_cnt, fail_cnt);
		if (fail_cnt == 0 && num_lines > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/int_pipe_stimulus.txt
// columns: pc, instruction, valid (strobe and expected wb valid), illegal, rd, data
// data is ignored when illegal is set
00001000 00000000 0 0 00 00000000 // idle
00001004 00000000 0 0 00 00000000 // idle
00001008 000382b3 1 0 05 00000000 // add x5, x7, x0
0000100c 00500093 1 0 01 00000005 // addi x1, x0, 5
00001010 ffd00113 1 0 02 fffffffd // addi x2, x0, -3
00001014 ffe12193 1 0 03 00000001 // slti x3, x2, -2
00001018 fff0b213 1 0 04 00000001 // sltiu x4, x1, -1
0000101c 0f014313 1 0 06 ffffff0d // xori x6, x2, 0xf0
00001020 7000e393 1 0 07 00000705 // ori x7, x1, 0x700
00001024 0ff3f413 1 0 08 00000005 // andi x8, x7, 0xff
00001028 00409493 1 0 09 00000050 // slli x9, x1, 4
0000102c 00815513 1 0 0a 00ffffff // srli x10, x2, 8
00001030 40815593 1 0 0b ffffffff // srai x11, x2, 8
00001034 12345637 1 0 0c 12345000 // lui x12, 0x12345
00001038 00010697 1 0 0d 00011038 // auipc x13, 0x10
0000103c 00208733 1 0 0e 00000002 // add x14, x1, x2
00001040 401707b3 1 0 0f fffffffd // sub x15, x14, x1
00001044 00e79833 1 0 10 fffffff4 // sll x16, x15, x14
00001048 001828b3 1 0 11 00000001 // slt x17, x16, x1
0000104c 00183933 1 0 12 00000000 // sltu x18, x16, x1
00001050 011949b3 1 0 13 00000001 // xor x19, x18, x17
00001054 01385a33 1 0 14 7ffffffa // srl x20, x16, x19
00001058 41385ab3 1 0 15 fffffffa // sra x21, x16, x19
0000105c 015a6b33 1 0 16 fffffffa // or x22, x20, x21
00001060 014b7bb3 1 0 17 7ffffffa // and x23, x22, x20
00001064 00708013 1 0 00 0000000c // addi x0, x1, 7
00001068 00000c33 1 0 18 00000000 // add x24, x0, x0
0000106c 00012083 1 1 01 00000000 // lw x1, 0(x2)
00001070 20108133 1 1 02 00000000 // op with funct7 0x10
00001074 00000000 0 0 00 00000000 // idle
00001078 00008cb3 1 0 19 00000005 // add x25, x1, x0
0000107c 00010d33 1 0 1a fffffffd // add x26, x2, x0
00001080 00000000 0 0 00 00000000 // idle

// File: flist.f
+incdir+common
common/riscv_pkg.sv
id/reg_bank.sv
id/control_unit.sv
id/id_stage.sv
source/alu.sv
source/ex_stage.sv
source/int_pipe_top.sv
sim/int_pipe_tb.sv
